/* design/axi_pkg.sv */
`default_nettype none

package axi_pkg;

    // Bus widths
    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 32;
    localparam int ID_BITS   = 4;

    // Basic AXI field types
    typedef logic [ADDR_BITS-1:0]   addr_t;
    typedef logic [DATA_BITS-1:0]   data_t;
    typedef logic [ID_BITS-1:0]     id_t;
    // One strobe bit per data byte
    typedef logic [DATA_BITS/8-1:0] wstrb_t;
    typedef logic [7:0]             len_t;
    typedef logic [2:0]             size_t;
    typedef logic [1:0]             resp_t;

    // Response codes
    localparam resp_t AXI_RESP_OKAY   = 2'b00;
    localparam resp_t AXI_RESP_SLVERR = 2'b10;
    localparam resp_t AXI_RESP_DECERR = 2'b11;

    // Manager to subordinate
    typedef struct packed {
        // Write address
        logic   awvalid;
        addr_t  awaddr;
        len_t   awlen;
        size_t  awsize;
        id_t    awid;
        // Write data
        logic   wvalid;
        data_t  wdata;
        wstrb_t wstrb;
        logic   wlast;
        // Response readies
        logic   bready;
        logic   rready;
        // Read address
        logic   arvalid;
        addr_t  araddr;
        len_t   arlen;
        size_t  arsize;
        id_t    arid;
    } req_s;

    // Subordinate to manager
    typedef struct packed {
        // Address and data readies
        logic   awready;
        logic   wready;
        logic   arready;
        // Write response
        logic   bvalid;
        id_t    bid;
        resp_t  bresp;
        // Read data
        logic   rvalid;
        data_t  rdata;
        id_t    rid;
        resp_t  rresp;
        logic   rlast;
    } rsp_s;

    // One command from the command port
    typedef struct packed {
        logic   write;
        addr_t  addr;
        // Passed unchanged onto awlen or arlen
        len_t   len;
        id_t    id;
        data_t  data;
        wstrb_t strb;
    } cmd_s;

    // Outcome of one finished transaction
    typedef struct packed {
        logic   write;
        id_t    id;
        resp_t  resp;
        // Zero for writes
        data_t  rdata;
    } result_s;

endpackage

`default_nettype wire

/* design/byte_lane_ram.sv */
`default_nettype none

module byte_lane_ram #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         axi_global,
    // Write port
    input  logic                         we,
    input  axi_pkg::wstrb_t              wstrb,
    input  logic [$clog2(MEM_WORDS)-1:0] waddr,
    input  axi_pkg::data_t               wdata,
    // Read port
    input  logic [$clog2(MEM_WORDS)-1:0] raddr,
    output axi_pkg::data_t               rdata
);

    // Number of byte lanes in a word
    localparam int LANES = axi_pkg::DATA_BITS / 8;

    // Word storage, contents undefined after power up
    axi_pkg::data_t mem [MEM_WORDS];

    // Byte lane writes
    always_ff @(posedge axi_global) begin
        if (we) begin
            for (int lane = 0; lane < LANES; lane++) begin
                // Only lanes with their strobe set change
                if (wstrb[lane]) begin
                    mem[waddr][lane*8 +: 8] <= wdata[lane*8 +: 8];
                end
            end
        end
    end

    // Registered read
    // Data appears one cycle after raddr
    always_ff @(posedge axi_global) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* design/axi_sram_subordinate.sv */
`default_nettype none

module axi_sram_subordinate #(
    parameter int MEM_WORDS = 256
) (
    input  logic          axi_global,
    input  logic          rst_n,
    input  axi_pkg::req_s req,
    output axi_pkg::rsp_s rsp
);

    // Byte offset bits inside a word and word index bits
    localparam int BYTE_BITS = $clog2(axi_pkg::DATA_BITS / 8);
    localparam int WORD_BITS = $clog2(MEM_WORDS);

    // Burst first, then range
    function automatic axi_pkg::resp_t classify(
        input axi_pkg::addr_t addr,
        input axi_pkg::len_t  len
    );
        axi_pkg::addr_t word;
        word = addr >> BYTE_BITS;
        if (len != '0) begin
            classify = axi_pkg::AXI_RESP_SLVERR;
        end else if (word >= axi_pkg::addr_t'(MEM_WORDS)) begin
            classify = axi_pkg::AXI_RESP_DECERR;
        end else begin
            classify = axi_pkg::AXI_RESP_OKAY;
        end
    endfunction

    // AW holding slot
    logic                 aw_full;
    axi_pkg::addr_t       aw_addr;
    axi_pkg::len_t        aw_len;
    axi_pkg::id_t         aw_id;
    // W holding slot
    logic                 w_full;
    axi_pkg::data_t       w_data;
    axi_pkg::wstrb_t      w_strb;
    logic                 w_last;
    // B response register
    logic                 b_valid;
    axi_pkg::id_t         b_id;
    axi_pkg::resp_t       b_resp;
    // Accepted read waiting on the RAM
    logic                 ar_pending;
    axi_pkg::resp_t       ar_resp;
    axi_pkg::id_t         ar_id;
    // R response register
    logic                 r_valid;
    axi_pkg::data_t       r_data;
    axi_pkg::id_t         r_id;
    axi_pkg::resp_t       r_resp;
    // Handshakes and RAM hookup
    logic                 aw_xfer, w_xfer, b_xfer, ar_xfer, r_xfer;
    logic                 wr_go;
    axi_pkg::resp_t       wr_resp;
    logic                 ram_we;
    logic [WORD_BITS-1:0] ram_waddr;
    logic [WORD_BITS-1:0] ram_raddr;
    axi_pkg::data_t       ram_rdata;

    // Outputs straight from the registers
    always_comb begin
        rsp.awready = !aw_full;
        rsp.wready  = !w_full;
        // No new read until the last one is answered
        rsp.arready = !ar_pending && !r_valid;
        rsp.bvalid  = b_valid;
        rsp.bid     = b_id;
        rsp.bresp   = b_resp;
        rsp.rvalid  = r_valid;
        rsp.rdata   = r_data;
        rsp.rid     = r_id;
        rsp.rresp   = r_resp;
        // Single beat, always the last
        rsp.rlast   = 1'b1;
    end

    assign aw_xfer = req.awvalid && rsp.awready;
    assign w_xfer  = req.wvalid && rsp.wready;
    assign b_xfer  = b_valid && req.bready;
    assign ar_xfer = req.arvalid && rsp.arready;
    assign r_xfer  = r_valid && req.rready;

    // Both slots full and no response out yet
    assign wr_go   = aw_full && w_full && !b_valid;
    // A W beat without wlast also means a burst
    assign wr_resp = !w_last ? axi_pkg::AXI_RESP_SLVERR : classify(aw_addr, aw_len);
    assign ram_we  = wr_go && (wr_resp == axi_pkg::AXI_RESP_OKAY);

    // Word index from the byte address
    assign ram_waddr = aw_addr[BYTE_BITS +: WORD_BITS];
    assign ram_raddr = req.araddr[BYTE_BITS +: WORD_BITS];

    // Control state
    always_ff @(posedge axi_global or negedge rst_n) begin
        if (!rst_n) begin
            aw_full    <= 1'b0;
            w_full     <= 1'b0;
            b_valid    <= 1'b0;
            ar_pending <= 1'b0;
            r_valid    <= 1'b0;
        end else begin
            // Slots stay full until the B transfer
            if (aw_xfer) begin
                aw_full <= 1'b1;
            end else if (b_xfer) begin
                aw_full <= 1'b0;
            end
            if (w_xfer) begin
                w_full <= 1'b1;
            end else if (b_xfer) begin
                w_full <= 1'b0;
            end
            if (wr_go) begin
                b_valid <= 1'b1;
            end else if (b_xfer) begin
                b_valid <= 1'b0;
            end
            // RAM data is ready one cycle after AR
            ar_pending <= ar_xfer;
            if (ar_pending) begin
                r_valid <= 1'b1;
            end else if (r_xfer) begin
                r_valid <= 1'b0;
            end
        end
    end

    // Payload registers
    always_ff @(posedge axi_global) begin
        if (aw_xfer) begin
            aw_addr <= req.awaddr;
            aw_len  <= req.awlen;
            aw_id   <= req.awid;
        end
        if (w_xfer) begin
            w_data <= req.wdata;
            w_strb <= req.wstrb;
            w_last <= req.wlast;
        end
        if (wr_go) begin
            b_id   <= aw_id;
            b_resp <= wr_resp;
        end
        if (ar_xfer) begin
            ar_resp <= classify(req.araddr, req.arlen);
            ar_id   <= req.arid;
        end
        // Error responses carry zero data
        if (ar_pending) begin
            r_id   <= ar_id;
            r_resp <= ar_resp;
            r_data <= (ar_resp == axi_pkg::AXI_RESP_OKAY) ? ram_rdata : '0;
        end
    end

    byte_lane_ram #(
        .MEM_WORDS(MEM_WORDS)
    ) ram_inst (
        .axi_global(axi_global),
        .we        (ram_we),
        .wstrb     (w_strb),
        .waddr     (ram_waddr),
        .wdata     (w_data),
        .raddr     (ram_raddr),
        .rdata     (ram_rdata)
    );

endmodule

`default_nettype wire

/* design/axi_single_beat_manager.sv */
`default_nettype none

module axi_single_beat_manager (
    input  logic             axi_global,
    input  logic             rst_n,
    // Command port
    input  logic             cmd_valid,
    input  axi_pkg::cmd_s    cmd,
    output logic             busy,
    output logic             done,
    output axi_pkg::result_s result,
    // AXI side
    input  axi_pkg::rsp_s    rsp,
    output axi_pkg::req_s    req
);

    // Full bus width beats only
    localparam axi_pkg::size_t BEAT_SIZE =
        axi_pkg::size_t'($clog2(axi_pkg::DATA_BITS / 8));

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_RESP
    } state_t;

    state_t        state;
    // Command held for the whole transaction
    axi_pkg::cmd_s cmd_q;
    logic          aw_valid, w_valid, ar_valid;
    logic          b_ready, r_ready;
    logic          accept;
    logic          aw_xfer, w_xfer, ar_xfer, b_xfer, r_xfer;
    // Valids still owed after this edge
    logic          aw_next, w_next, ar_next;

    // Strobes while busy are dropped
    assign accept = cmd_valid && (state == ST_IDLE);
    assign busy   = (state != ST_IDLE);

    assign aw_xfer = aw_valid && rsp.awready;
    assign w_xfer  = w_valid && rsp.wready;
    assign ar_xfer = ar_valid && rsp.arready;
    assign b_xfer  = b_ready && rsp.bvalid;
    assign r_xfer  = r_ready && rsp.rvalid;

    // Each valid drops on its own transfer
    assign aw_next = aw_valid && !aw_xfer;
    assign w_next  = w_valid && !w_xfer;
    assign ar_next = ar_valid && !ar_xfer;

    // FSM and handshake flags
    always_ff @(posedge axi_global or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            ar_valid <= 1'b0;
            b_ready  <= 1'b0;
            r_ready  <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // AW and W go up together on a write
                    if (accept) begin
                        aw_valid <= cmd.write;
                        w_valid  <= cmd.write;
                        ar_valid <= !cmd.write;
                        state    <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    aw_valid <= aw_next;
                    w_valid  <= w_next;
                    ar_valid <= ar_next;
                    // All address and data sent, wait for the answer
                    if (!aw_next && !w_next && !ar_next) begin
                        b_ready <= cmd_q.write;
                        r_ready <= !cmd_q.write;
                        state   <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (b_xfer || r_xfer) begin
                        b_ready <= 1'b0;
                        r_ready <= 1'b0;
                        done    <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Command and result payload
    always_ff @(posedge axi_global) begin
        if (accept) begin
            cmd_q <= cmd;
        end
        if (b_xfer) begin
            result.write <= 1'b1;
            result.id    <= rsp.bid;
            result.resp  <= rsp.bresp;
            result.rdata <= '0;
        end else if (r_xfer) begin
            result.write <= 1'b0;
            result.id    <= rsp.rid;
            result.resp  <= rsp.rresp;
            result.rdata <= rsp.rdata;
        end
    end

    // Request bus built from the held command
    always_comb begin
        req.awvalid = aw_valid;
        req.awaddr  = cmd_q.addr;
        req.awlen   = cmd_q.len;
        req.awsize  = BEAT_SIZE;
        req.awid    = cmd_q.id;
        req.wvalid  = w_valid;
        req.wdata   = cmd_q.data;
        req.wstrb   = cmd_q.strb;
        // One beat per write
        req.wlast   = 1'b1;
        req.bready  = b_ready;
        req.rready  = r_ready;
        req.arvalid = ar_valid;
        req.araddr  = cmd_q.addr;
        req.arlen   = cmd_q.len;
        req.arsize  = BEAT_SIZE;
        req.arid    = cmd_q.id;
    end

endmodule

`default_nettype wire

/* design/axi_mem_system.sv */
`default_nettype none

module axi_mem_system #(
    // Memory depth in words
    parameter int MEM_WORDS = 256
) (
    input  logic             axi_global,
    input  logic             rst_n,
    // Command port
    input  logic             cmd_valid,
    input  axi_pkg::cmd_s    cmd,
    output logic             busy,
    output logic             done,
    output axi_pkg::result_s result
);

    // AXI link between manager and memory
    axi_pkg::req_s req;
    axi_pkg::rsp_s rsp;

    axi_single_beat_manager manager_inst (
        .axi_global(axi_global),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .result    (result),
        .rsp       (rsp),
        .req       (req)
    );

    axi_sram_subordinate #(
        .MEM_WORDS(MEM_WORDS)
    ) subordinate_inst (
        .axi_global(axi_global),
        .rst_n     (rst_n),
        .req       (req),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

/* bench/axi_mem_model.svh */
`ifndef AXI_MEM_MODEL_SVH
`define AXI_MEM_MODEL_SVH

// Shadow copy of memory, one flag per word once written in full
axi_pkg::data_t shadow_mem   [MEM_WORDS];
bit             shadow_known [MEM_WORDS];

// Nothing known before the first write
function automatic void clear_shadow();
    for (int i = 0; i < MEM_WORDS; i++) begin
        shadow_mem[i]   = '0;
        shadow_known[i] = 1'b0;
    end
endfunction

// Word slot inside the memory, byte offset dropped
function automatic logic [INDEX_BITS-1:0] word_slot(input axi_pkg::addr_t addr);
    return addr[2 +: INDEX_BITS];
endfunction

// A burst is refused before the range is looked at
function automatic axi_pkg::resp_t expected_resp(input axi_pkg::cmd_s c);
    if (c.len != 8'd0) begin
        return axi_pkg::AXI_RESP_SLVERR;
    end
    if ((c.addr >> 2) >= axi_pkg::addr_t'(MEM_WORDS)) begin
        return axi_pkg::AXI_RESP_DECERR;
    end
    return axi_pkg::AXI_RESP_OKAY;
endfunction

// Only strobed bytes take the new value
function automatic axi_pkg::data_t merge_bytes(
    input axi_pkg::data_t  old_word,
    input axi_pkg::data_t  new_word,
    input axi_pkg::wstrb_t strb
);
    axi_pkg::data_t merged;
    merged = old_word;
    for (int lane = 0; lane < 4; lane++) begin
        if (strb[lane]) begin
            merged[lane*8 +: 8] = new_word[lane*8 +: 8];
        end
    end
    return merged;
endfunction

// Writes and refused reads return zero data
function automatic axi_pkg::data_t expected_rdata(input axi_pkg::cmd_s c);
    if (c.write || (expected_resp(c) != axi_pkg::AXI_RESP_OKAY)) begin
        return '0;
    end
    return shadow_mem[word_slot(c.addr)];
endfunction

// Accepted writes land in the shadow copy
function automatic void update_shadow(input axi_pkg::cmd_s c);
    logic [INDEX_BITS-1:0] slot;
    slot = word_slot(c.addr);
    if (c.write && (expected_resp(c) == axi_pkg::AXI_RESP_OKAY)) begin
        shadow_mem[slot] = merge_bytes(shadow_mem[slot], c.data, c.strb);
        // Full word written, every byte now defined
        if (c.strb == 4'hF) begin
            shadow_known[slot] = 1'b1;
        end
    end
endfunction

`endif

/* bench/axi_mem_system_tb.sv */
`default_nettype none

module axi_mem_system_tb;

    localparam int          MEM_WORDS      = 256;
    localparam int          INDEX_BITS     = $clog2(MEM_WORDS);
    localparam int          DRIVE_DELAY    = 10;
    localparam int          TIMEOUT_CYCLES = 20;
    localparam int          MIX_COMMANDS   = 400;
    localparam int unsigned SEED           = 81010;

    // Byte address bits that select a word slot
    localparam axi_pkg::addr_t SLOT_MASK = axi_pkg::addr_t'((MEM_WORDS - 1) << 2);

    logic             axi_global;
    logic             rst_n;
    logic             cmd_valid;
    axi_pkg::cmd_s    cmd;
    logic             busy;
    logic             done;
    axi_pkg::result_s result;

    // Addresses reused across the directed phases
    axi_pkg::addr_t   picked [16];
    int               commands_run;

    `include "axi_mem_model.svh"

    axi_mem_system #(
        .MEM_WORDS(MEM_WORDS)
    ) axi_mem_system_inst (
        .axi_global(axi_global),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .result    (result)
    );

    // Period 100
    initial begin
        axi_global = 1'b0;
        forever begin
            #50;
            axi_global = ~axi_global;
        end
    end

    // One cycle, landing just after the rising edge
    task automatic tick();
        @(posedge axi_global);
        #(DRIVE_DELAY);
    endtask

    task automatic check_value(
        input logic [63:0] expected,
        input logic [63:0] actual,
        input string       what
    );
        if (expected !== actual) begin
            $display("[ERROR] %0t %s: expected %0h, got %0h", $time, what, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic wait_until_idle();
        int cycles;
        cycles = 0;
        while (busy) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timed out at %0t: busy stayed high for %0d cycles",
                         $time, TIMEOUT_CYCLES);
                $display("Testbench failed");
                $fatal(1, "Stopped on a timeout");
            end else begin
                tick();
                cycles++;
            end
        end
    endtask

    // A word gets a full write before any partial write or read of it
    function automatic axi_pkg::cmd_s first_touch(input axi_pkg::cmd_s c);
        axi_pkg::cmd_s fixed;
        fixed = c;
        if ((expected_resp(c) == axi_pkg::AXI_RESP_OKAY) && !shadow_known[word_slot(c.addr)]) begin
            fixed.write = 1'b1;
            fixed.strb  = 4'hF;
        end
        return fixed;
    endfunction

    function automatic axi_pkg::addr_t random_addr(input bit in_range);
        axi_pkg::addr_t word;
        if (in_range) begin
            word = axi_pkg::addr_t'($urandom % MEM_WORDS);
        end else begin
            // Past the last word, anywhere up to the top of the map
            word = axi_pkg::addr_t'(MEM_WORDS) + axi_pkg::addr_t'($urandom % 32'h3FFF_FF00);
        end
        return word << 2;
    endfunction

    function automatic axi_pkg::cmd_s build_command(
        input logic           write,
        input axi_pkg::addr_t addr,
        input axi_pkg::len_t  len
    );
        axi_pkg::cmd_s c;
        c.write = write;
        c.addr  = addr;
        c.len   = len;
        c.id    = axi_pkg::id_t'($urandom);
        c.data  = axi_pkg::data_t'($urandom);
        c.strb  = axi_pkg::wstrb_t'($urandom);
        return first_touch(c);
    endfunction

    // Mostly plain beats, one in ten a burst, one in ten out of range
    function automatic axi_pkg::cmd_s random_command();
        int unsigned   kind;
        axi_pkg::len_t len;
        kind = $urandom % 10;
        len  = (kind == 0) ? axi_pkg::len_t'(1 + $urandom % 255) : 8'd0;
        return build_command(1'($urandom), random_addr(kind != 1), len);
    endfunction

    // Issue one command, optionally poke cmd_valid while busy, check its result
    task automatic run_command(input axi_pkg::cmd_s c, input bit strobe_while_busy);
        axi_pkg::resp_t exp_resp;
        axi_pkg::data_t exp_data;
        int             cycles;
        wait_until_idle();
        exp_resp = expected_resp(c);
        exp_data = expected_rdata(c);
        update_shadow(c);
        cmd       = c;
        cmd_valid = 1'b1;
        tick();
        check_value(64'(1'b1), 64'(busy), "busy after accept");
        if (strobe_while_busy) begin
            // Opposite direction on the same word, must be dropped
            cmd       = random_command();
            cmd.write = !c.write;
            cmd.addr  = c.addr;
            cmd.len   = '0;
            tick();
        end
        cmd_valid = 1'b0;
        cycles    = 0;
        while (!done) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("Timed out at %0t: no done within %0d cycles of a command",
                         $time, TIMEOUT_CYCLES);
                $display("Testbench failed");
                $fatal(1, "Stopped on a timeout");
            end else begin
                tick();
                cycles++;
            end
        end
        check_value(64'(1'b0), 64'(busy), "busy at done");
        check_value(64'(c.write), 64'(result.write), "result write flag");
        check_value(64'(c.id), 64'(result.id), "result id");
        check_value(64'(exp_resp), 64'(result.resp), "result response");
        check_value(64'(exp_data), 64'(result.rdata), "result read data");
        // Done lasts one cycle and nothing else gets started
        tick();
        check_value(64'(1'b0), 64'(done), "done after its pulse");
        check_value(64'(1'b0), 64'(busy), "busy after done");
        commands_run++;
    endtask

    initial begin
        axi_pkg::addr_t far_addr;
        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        commands_run = 0;
        void'($urandom(SEED));
        clear_shadow();
        repeat (4) @(posedge axi_global);
        #(DRIVE_DELAY);
        rst_n = 1'b1;

        // Quiet after reset
        for (int i = 0; i < 6; i++) begin
            check_value(64'(1'b0), 64'(busy), "busy after reset");
            check_value(64'(1'b0), 64'(done), "done after reset");
            tick();
        end

        // Full write, partial overwrite, then read back
        for (int i = 0; i < 16; i++) begin
            picked[i] = random_addr(1'b1);
            run_command(build_command(1'b1, picked[i], 8'd0), 1'b0);
            run_command(build_command(1'b1, picked[i], 8'd0), 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            run_command(build_command(1'b0, picked[i], 8'd0), 1'b0);
        end

        // Bursts refused, contents kept
        for (int i = 0; i < 8; i++) begin
            run_command(build_command(1'b1, picked[i], axi_pkg::len_t'(1 + $urandom % 255)), 1'b0);
            run_command(build_command(1'b0, picked[i], axi_pkg::len_t'(1 + i)), 1'b0);
            run_command(build_command(1'b0, picked[i], 8'd0), 1'b0);
        end

        // Out of range, first exactly at index 256
        for (int i = 0; i < 8; i++) begin
            if (i == 0) begin
                far_addr = axi_pkg::addr_t'(MEM_WORDS) << 2;
            end else begin
                // Aliases the slot of the in-range word read back below
                far_addr = (random_addr(1'b0) & ~SLOT_MASK) | (picked[i + 8] & SLOT_MASK);
            end
            run_command(build_command(1'b1, far_addr, 8'd0), 1'b0);
            run_command(build_command(1'b0, far_addr, 8'd0), 1'b0);
            run_command(build_command(1'b0, picked[i + 8], 8'd0), 1'b0);
        end

        // Strobes during busy, then read back for stray writes
        for (int i = 0; i < 16; i++) begin
            run_command(build_command(1'(i % 2), picked[i], 8'd0), 1'b1);
        end
        for (int i = 0; i < 16; i++) begin
            run_command(build_command(1'b0, picked[i], 8'd0), 1'b0);
        end

        // Long random mix
        for (int i = 0; i < MIX_COMMANDS; i++) begin
            run_command(random_command(), ($urandom % 8) == 0);
        end

        $display("Ran %0d commands", commands_run);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* axi_mem_system.f */
+incdir+bench
design/axi_pkg.sv
design/byte_lane_ram.sv
design/axi_sram_subordinate.sv
design/axi_single_beat_manager.sv
design/axi_mem_system.sv
bench/axi_mem_system_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module axi_mem_system_tb \
    -f axi_mem_system.f \
    --Mdir obj_dir \
    -o axi_mem_system_sim

./obj_dir/axi_mem_system_sim
